//--- compile.f
+incdir+verif
logic/osf_stream_pkg.sv
logic/osf_ctl_pkg.sv
logic/osf_stream_fifo.sv
logic/osf_frame_merge.sv
logic/osf_egress_stats.sv
logic/osf_core.sv
verif/osf_core_tb.sv

//--- Makefile
# Verilator build and run for the OSF core testbench.
# Override any variable on the command line, e.g. make LOG=run1.log

VERILATOR  ?= verilator
TOP        ?= osf_core_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
SOURCES    := $(wildcard logic/*.sv verif/*.sv verif/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/osf_core_tb_checks.svh
////////////////////////////////////////////////////////////
// Reference model and compare tasks for osf_core_tb. Goes
// inside the testbench module after its beat queues and
// error counters are declared.
////////////////////////////////////////////////////////////
`ifndef OSF_CORE_TB_CHECKS_SVH
`define OSF_CORE_TB_CHECKS_SVH

// one whole pdt frame, then one whole data frame, and so on.
function automatic void ref_interleave(input int p_first, input int p_stop,
                                       input int d_first, input int d_stop);
  osf_stream_pkg::axis_bus_t beat;
  int p;
  int d;
  p = p_first;
  d = d_first;
  while (p < p_stop || d < d_stop)
  begin
    while (p < p_stop)
    begin
      beat = pdt_beats[p];
      p++;
      exp_q.push_back(beat);
      if (beat.tlast)
        break;
    end
    while (d < d_stop)
    begin
      beat = data_beats[d];
      d++;
      exp_q.push_back(beat);
      if (beat.tlast)
        break;
    end
  end
endfunction

// valid bytes of one beat.
function automatic osf_ctl_pkg::byte_cnt_t strobe_bytes(input osf_stream_pkg::osf_strb_t strb);
  return osf_ctl_pkg::byte_cnt_t'($countones(strb));
endfunction

task automatic check_beat(input osf_stream_pkg::axis_bus_t got,
                          input osf_stream_pkg::axis_bus_t exp, input string name);
  if (got !== exp)
  begin
    beat_errs++;
    $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_amt(input osf_ctl_pkg::byte_cnt_t got,
                         input osf_ctl_pkg::byte_cnt_t exp, input string name);
  if (got !== exp)
  begin
    amt_errs++;
    $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_stats(input osf_ctl_pkg::osf_stats_t got,
                           input osf_ctl_pkg::osf_stats_t exp, input string name);
  if (got !== exp)
  begin
    stat_errs++;
    $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
  if (got !== exp)
  begin
    bit_errs++;
    $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_count(input int got, input int exp, input string name);
  if (got != exp)
  begin
    misc_errs++;
    $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
  end
endtask

`endif

//--- verif/osf_core_tb.sv
////////////////////////////////////////////////////////////
// Testbench for osf_core. All frames are built up front and
// sent in three phases: one frame per lane, random ready
// with idle gaps, then random ready under halt windows.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osf_core_tb;

  localparam int N_PHASES = 3;

  logic                      clk;
  logic                      arst_n;
  osf_stream_pkg::axis_bus_t osf_ib_in;
  logic                      osf_ib_ready;
  osf_stream_pkg::axis_bus_t osf_cg_ib_in;
  logic                      osf_cg_ib_ready;
  osf_stream_pkg::axis_bus_t osf_ob_out;
  logic                      osf_ob_ready;
  logic                      sup_osf_halt;
  osf_ctl_pkg::osf_stats_t   osf_stat_events;
  logic                      ob_bytes_cnt_stb;
  osf_ctl_pkg::byte_cnt_t    ob_bytes_cnt_amt;
  logic                      ob_frame_cnt_stb;

  osf_stream_pkg::axis_bus_t pdt_beats[$];
  osf_stream_pkg::axis_bus_t data_beats[$];
  osf_stream_pkg::axis_bus_t exp_q[$];
  osf_stream_pkg::axis_bus_t exp_beat;
  int pdt_mark[N_PHASES+1];
  int data_mark[N_PHASES+1];
  int phase_frames[N_PHASES] = '{1, 20, 12};
  int n_frames = 0;
  int beat_errs = 0;
  int amt_errs = 0;
  int stat_errs = 0;
  int bit_errs = 0;
  int misc_errs = 0;
  int ob_beats = 0;
  int ob_frames = 0;
  int ib_frames = 0;
  int cg_frames = 0;
  int watchdog_cycles;
  int total_errs;
  bit ob_ready_random = 1'b0;
  logic                    ob_xfer;
  logic                    prev_xfer = 1'b0;
  osf_ctl_pkg::byte_cnt_t  prev_amt = '0;
  osf_ctl_pkg::osf_stats_t prev_stats = '0;

  `include "osf_core_tb_checks.svh"

  osf_core #(
    .DATA_FIFO_ENTRIES (8),
    .PDT_FIFO_ENTRIES  (8),
    .OB_FIFO_ENTRIES   (4)
  ) u_osf_core (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    osf_ob_ready = 1'b1;
    forever
    begin
      @(negedge clk);
      osf_ob_ready = ob_ready_random ? ($urandom_range(3) != 0) : 1'b1;
    end
  end

  task automatic make_frames(input bit pdt_lane, input int count);
    osf_stream_pkg::axis_bus_t beat;
    int len;
    for (int f = 0; f < count; f++)
    begin
      len = int'($urandom_range(6, 1));
      for (int b = 0; b < len; b++)
      begin
        beat.tvalid = 1'b1;
        beat.tlast  = (b == len - 1);
        beat.tuser  = osf_stream_pkg::osf_user_t'($urandom);
        beat.tstrb  = osf_stream_pkg::osf_strb_t'($urandom);
        beat.tdata  = {$urandom, $urandom};
        if (pdt_lane)
          pdt_beats.push_back(beat);
        else
          data_beats.push_back(beat);
      end
    end
  endtask

  task automatic set_lane(input bit pdt_lane, input osf_stream_pkg::axis_bus_t bus);
    if (pdt_lane)
      osf_cg_ib_in = bus;
    else
      osf_ib_in = bus;
  endtask

  task automatic drive_lane(input bit pdt_lane, input int first, input int stop,
                            input bit gaps);
    osf_stream_pkg::axis_bus_t beat;
    logic rdy;
    int   idle;
    for (int i = first; i < stop; i++)
    begin
      beat = pdt_lane ? pdt_beats[i] : data_beats[i];
      idle = gaps ? int'($urandom_range(2)) : 0;
      @(negedge clk);
      if (idle > 0)
      begin
        set_lane(pdt_lane, '0);
        repeat (idle) @(negedge clk);
      end
      set_lane(pdt_lane, beat);
      do
      begin
        @(posedge clk);
        rdy = pdt_lane ? osf_cg_ib_ready : osf_ib_ready;  // held until accepted.
      end
      while (!rdy);
    end
    @(negedge clk);
    set_lane(pdt_lane, '0);
  endtask

  task automatic toggle_halt();
    repeat (4)
    begin
      repeat (15) @(negedge clk);
      sup_osf_halt = 1'b1;
      repeat (20) @(negedge clk);
      sup_osf_halt = 1'b0;
    end
  endtask

  task automatic run_phase(input int k, input bit gaps, input bit halts);
    ref_interleave(pdt_mark[k], pdt_mark[k+1], data_mark[k], data_mark[k+1]);
    fork
      drive_lane(1'b1, pdt_mark[k], pdt_mark[k+1], gaps);
      drive_lane(1'b0, data_mark[k], data_mark[k+1], gaps);
      if (halts)
        toggle_halt();
    join
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);  // let the last strobes land.
  endtask

  // scoreboard. strobes are checked against the previous edge.
  always @(posedge clk)
  begin
    if (arst_n)
    begin
      check_bit(ob_bytes_cnt_stb, prev_xfer, "ob_bytes_cnt_stb");
      check_bit(ob_frame_cnt_stb, prev_stats.ob_frame, "ob_frame_cnt_stb");
      check_stats(osf_stat_events, prev_stats, "osf_stat_events");
      if (prev_xfer)
        check_amt(ob_bytes_cnt_amt, prev_amt, "ob_bytes_cnt_amt");
      ib_frames += int'(osf_stat_events.ib_frame);
      cg_frames += int'(osf_stat_events.cg_frame);
      ob_frames += int'(osf_stat_events.ob_frame);
      if (sup_osf_halt && osf_ob_out.tvalid)
      begin
        misc_errs++;
        $display("outbound tvalid was high at %0t while sup_osf_halt was set", $time);
      end
      ob_xfer             = osf_ob_out.tvalid & osf_ob_ready;
      prev_amt            = '0;
      prev_stats.ob_frame = 1'b0;
      if (ob_xfer)
      begin
        ob_beats++;
        if (exp_q.size() == 0)
        begin
          misc_errs++;
          $display("outbound beat at %0t with no beat left to expect", $time);
        end
        else
        begin
          exp_beat = exp_q.pop_front();
          check_beat(osf_ob_out, exp_beat, "osf_ob_out");
          prev_amt            = strobe_bytes(exp_beat.tstrb);
          prev_stats.ob_frame = exp_beat.tlast;
        end
      end
      prev_xfer           = ob_xfer;
      prev_stats.ib_frame = osf_ib_in.tvalid & osf_ib_ready & osf_ib_in.tlast;
      prev_stats.cg_frame = osf_cg_ib_in.tvalid & osf_cg_ib_ready & osf_cg_ib_in.tlast;
    end
  end

  initial
  begin
    void'($urandom(32'he0a9_d4ae));
    arst_n       = 1'b0;
    osf_ib_in    = '0;
    osf_cg_ib_in = '0;
    sup_osf_halt = 1'b0;
    for (int k = 0; k < N_PHASES; k++)
    begin
      pdt_mark[k]  = pdt_beats.size();
      data_mark[k] = data_beats.size();
      make_frames(1'b1, phase_frames[k]);
      make_frames(1'b0, phase_frames[k]);
      n_frames += phase_frames[k];
    end
    pdt_mark[N_PHASES]  = pdt_beats.size();
    data_mark[N_PHASES] = data_beats.size();
    watchdog_cycles = 40 * (pdt_beats.size() + data_beats.size()) + 1000;
    fork
      begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles with the stream stalled", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
      end
    join_none

    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_bit(osf_ob_out.tvalid, 1'b0, "osf_ob_out.tvalid");
    check_bit(ob_bytes_cnt_stb, 1'b0, "ob_bytes_cnt_stb");
    check_bit(ob_frame_cnt_stb, 1'b0, "ob_frame_cnt_stb");
    check_stats(osf_stat_events, '0, "osf_stat_events");
    check_bit(osf_ib_ready, 1'b1, "osf_ib_ready");
    check_bit(osf_cg_ib_ready, 1'b1, "osf_cg_ib_ready");

    run_phase(0, 1'b0, 1'b0);
    ob_ready_random = 1'b1;
    run_phase(1, 1'b1, 1'b0);
    run_phase(2, 1'b1, 1'b1);

    check_count(ib_frames, n_frames, "ib_frame pulses");
    check_count(cg_frames, n_frames, "cg_frame pulses");
    check_count(ob_frames, 2 * n_frames, "ob_frame pulses");
    check_count(ob_beats, pdt_beats.size() + data_beats.size(), "outbound beats");
    total_errs = beat_errs + amt_errs + stat_errs + bit_errs + misc_errs;
    $display("errors: beat %0d, amt %0d, stats %0d, strobe %0d, other %0d, total %0d",
             beat_errs, amt_errs, stat_errs, bit_errs, misc_errs, total_errs);
    if (total_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- logic/osf_core.sv
////////////////////////////////////////////////////////////
// OSF core. Data and pdt lanes are queued, merged frame by
// frame pdt first, queued again and sent out. FIFO depths are
// powers of two. Inbound readys drop only when a lane fills.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osf_core #(
  parameter int DATA_FIFO_ENTRIES = 16,
  parameter int PDT_FIFO_ENTRIES  = 16,
  parameter int OB_FIFO_ENTRIES   = 16
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  osf_stream_pkg::axis_bus_t osf_ib_in,
  output logic                      osf_ib_ready,
  input  osf_stream_pkg::axis_bus_t osf_cg_ib_in,
  output logic                      osf_cg_ib_ready,
  output osf_stream_pkg::axis_bus_t osf_ob_out,
  input  logic                      osf_ob_ready,
  input  logic                      sup_osf_halt,
  output osf_ctl_pkg::osf_stats_t   osf_stat_events,
  output logic                      ob_bytes_cnt_stb,
  output osf_ctl_pkg::byte_cnt_t    ob_bytes_cnt_amt,
  output logic                      ob_frame_cnt_stb
);

  osf_stream_pkg::axis_bus_t data_head;
  osf_stream_pkg::axis_bus_t pdt_head;
  osf_stream_pkg::axis_bus_t mrg_bus;
  osf_stream_pkg::axis_bus_t ob_head;
  logic                      data_head_ready;
  logic                      pdt_head_ready;
  logic                      mrg_ready;
  logic                      ob_pop;

  osf_stream_fifo #(
    .N_ENTRIES (DATA_FIFO_ENTRIES)
  ) u_data_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_bus    (osf_ib_in),
    .in_ready  (osf_ib_ready),
    .out_bus   (data_head),
    .out_ready (data_head_ready)
  );

  // cg inbound port carries the pdt frames.
  osf_stream_fifo #(
    .N_ENTRIES (PDT_FIFO_ENTRIES)
  ) u_pdt_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_bus    (osf_cg_ib_in),
    .in_ready  (osf_cg_ib_ready),
    .out_bus   (pdt_head),
    .out_ready (pdt_head_ready)
  );

  osf_frame_merge u_frame_merge (
    .clk        (clk),
    .arst_n     (arst_n),
    .pdt_bus    (pdt_head),
    .pdt_ready  (pdt_head_ready),
    .data_bus   (data_head),
    .data_ready (data_head_ready),
    .mrg_bus    (mrg_bus),
    .mrg_ready  (mrg_ready)
  );

  osf_stream_fifo #(
    .N_ENTRIES (OB_FIFO_ENTRIES)
  ) u_ob_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_bus    (mrg_bus),
    .in_ready  (mrg_ready),
    .out_bus   (ob_head),
    .out_ready (ob_pop)
  );

  osf_egress_stats u_egress_stats (
    .clk              (clk),
    .arst_n           (arst_n),
    .ob_head          (ob_head),
    .ob_pop           (ob_pop),
    .sup_osf_halt     (sup_osf_halt),
    .osf_ob_out       (osf_ob_out),
    .osf_ob_ready     (osf_ob_ready),
    .osf_ib_in        (osf_ib_in),
    .osf_ib_ready     (osf_ib_ready),
    .osf_cg_ib_in     (osf_cg_ib_in),
    .osf_cg_ib_ready  (osf_cg_ib_ready),
    .osf_stat_events  (osf_stat_events),
    .ob_bytes_cnt_stb (ob_bytes_cnt_stb),
    .ob_bytes_cnt_amt (ob_bytes_cnt_amt),
    .ob_frame_cnt_stb (ob_frame_cnt_stb)
  );

endmodule

//--- logic/osf_egress_stats.sv
////////////////////////////////////////////////////////////
// Outbound port and statistics. sup_osf_halt holds the port
// off with tvalid low. All strobes lag the transfer that
// caused them by one cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osf_egress_stats (
  input  logic                      clk,
  input  logic                      arst_n,
  input  osf_stream_pkg::axis_bus_t ob_head,
  output logic                      ob_pop,
  input  logic                      sup_osf_halt,
  output osf_stream_pkg::axis_bus_t osf_ob_out,
  input  logic                      osf_ob_ready,
  input  osf_stream_pkg::axis_bus_t osf_ib_in,
  input  logic                      osf_ib_ready,
  input  osf_stream_pkg::axis_bus_t osf_cg_ib_in,
  input  logic                      osf_cg_ib_ready,
  output osf_ctl_pkg::osf_stats_t   osf_stat_events,
  output logic                      ob_bytes_cnt_stb,
  output osf_ctl_pkg::byte_cnt_t    ob_bytes_cnt_amt,
  output logic                      ob_frame_cnt_stb
);

  logic ob_xfer;
  logic ob_xfer_last;
  logic ib_xfer_last;
  logic cg_xfer_last;

  function automatic osf_ctl_pkg::byte_cnt_t strb_count(osf_stream_pkg::osf_strb_t strb);
    osf_ctl_pkg::byte_cnt_t n;
    n = '0;
    for (int i = 0; i < $bits(strb); i++)
    begin
      n = n + osf_ctl_pkg::byte_cnt_t'(strb[i]);
    end
    return n;
  endfunction

  always_comb
  begin
    osf_ob_out        = ob_head;
    osf_ob_out.tvalid = ob_head.tvalid & ~sup_osf_halt;
  end

  assign ob_pop       = osf_ob_ready & ~sup_osf_halt;
  assign ob_xfer      = osf_ob_out.tvalid & osf_ob_ready;
  assign ob_xfer_last = ob_xfer & ob_head.tlast;
  assign ib_xfer_last = osf_ib_in.tvalid & osf_ib_ready & osf_ib_in.tlast;
  assign cg_xfer_last = osf_cg_ib_in.tvalid & osf_cg_ib_ready & osf_cg_ib_in.tlast;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      osf_stat_events  <= '0;
      ob_bytes_cnt_stb <= 1'b0;
      ob_bytes_cnt_amt <= '0;
      ob_frame_cnt_stb <= 1'b0;
    end
    else
    begin
      osf_stat_events.ib_frame <= ib_xfer_last;
      osf_stat_events.cg_frame <= cg_xfer_last;
      osf_stat_events.ob_frame <= ob_xfer_last;
      ob_frame_cnt_stb         <= ob_xfer_last;
      ob_bytes_cnt_stb         <= ob_xfer;
      // zero between strobes.
      ob_bytes_cnt_amt         <= ob_xfer ? strb_count(ob_head.tstrb) : '0;
    end
  end

endmodule

//--- logic/osf_frame_merge.sv
////////////////////////////////////////////////////////////
// Frame merger. Forwards one whole pdt frame, then one whole
// data frame, and repeats. A lane with no frame waiting
// stalls the other lane until it delivers one.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osf_frame_merge (
  input  logic                      clk,
  input  logic                      arst_n,
  input  osf_stream_pkg::axis_bus_t pdt_bus,
  output logic                      pdt_ready,
  input  osf_stream_pkg::axis_bus_t data_bus,
  output logic                      data_ready,
  output osf_stream_pkg::axis_bus_t mrg_bus,
  input  logic                      mrg_ready
);

  osf_ctl_pkg::merge_state_t state;
  osf_ctl_pkg::merge_state_t state_nxt;
  logic                      mrg_xfer;
  logic                      frame_done;

  // selected head passes straight through, no added cycle.
  always_comb
  begin
    if (state == osf_ctl_pkg::MRG_PDT)
    begin
      mrg_bus    = pdt_bus;
      pdt_ready  = mrg_ready;
      data_ready = 1'b0;
    end
    else
    begin
      mrg_bus    = data_bus;
      pdt_ready  = 1'b0;
      data_ready = mrg_ready;
    end
  end

  assign mrg_xfer   = mrg_bus.tvalid & mrg_ready;
  assign frame_done = mrg_xfer & mrg_bus.tlast;

  always_comb
  begin
    state_nxt = state;
    if (frame_done)
    begin
      case (state)
        osf_ctl_pkg::MRG_PDT:  state_nxt = osf_ctl_pkg::MRG_DATA;
        osf_ctl_pkg::MRG_DATA: state_nxt = osf_ctl_pkg::MRG_PDT;
        default:               state_nxt = osf_ctl_pkg::MRG_PDT;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= osf_ctl_pkg::MRG_PDT;  // pdt frame goes first.
    end
    else
    begin
      state <= state_nxt;
    end
  end

endmodule

//--- logic/osf_stream_fifo.sv
////////////////////////////////////////////////////////////
// Show-ahead stream FIFO. N_ENTRIES is a power of two, 2 or
// more. A beat written into an empty FIFO shows at the head
// one cycle later; there is no write-through path.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osf_stream_fifo #(
  parameter int N_ENTRIES = 16
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  osf_stream_pkg::axis_bus_t in_bus,
  output logic                      in_ready,
  output osf_stream_pkg::axis_bus_t out_bus,
  input  logic                      out_ready
);

  localparam int PTR_W  = $clog2(N_ENTRIES);
  localparam int CNT_W  = $clog2(N_ENTRIES + 1);
  localparam int BEAT_W = $bits(osf_stream_pkg::axis_bus_t) - 1;

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [BEAT_W-1:0] beat_t;  // beat minus tvalid.

  beat_t mem [N_ENTRIES];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  count;
  logic  push;
  logic  pop;
  logic  empty;

  assign empty    = (count == '0);
  assign in_ready = (count != cnt_t'(N_ENTRIES));
  assign push     = in_bus.tvalid & in_ready;
  assign pop      = out_bus.tvalid & out_ready;

  // head of queue, valid rebuilt from occupancy.
  assign out_bus = {~empty, mem[rd_ptr]};

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_bus[BEAT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n.
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/osf_ctl_pkg.sv
////////////////////////////////////////////////////////////
// Control and statistics types of the OSF core.
// Compile after osf_stream_pkg, which sets the strobe width.
////////////////////////////////////////////////////////////
package osf_ctl_pkg;

  // wide enough for a full beat of strobes, 0 to 8.
  localparam int BYTE_CNT_W = $clog2(osf_stream_pkg::OSF_STRB_W + 1);

  typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

  // lane the merger is draining.
  typedef enum logic {
    MRG_PDT  = 1'b0,
    MRG_DATA = 1'b1
  } merge_state_t;

  // one pulse per frame end on each port.
  typedef struct packed {
    logic ib_frame;   // data lane in.
    logic cg_frame;   // pdt lane in.
    logic ob_frame;
  } osf_stats_t;

endpackage

//--- logic/osf_stream_pkg.sv
////////////////////////////////////////////////////////////
// Stream types shared by the OSF core and its testbench.
// Payload is fixed at one 64-bit word per beat, and tstrb
// carries one bit per payload byte.
////////////////////////////////////////////////////////////
package osf_stream_pkg;

  localparam int OSF_DATA_W = 64;
  localparam int OSF_STRB_W = OSF_DATA_W / 8;
  localparam int OSF_USER_W = 2;

  typedef logic [OSF_DATA_W-1:0] osf_data_t;  // one beat of payload.
  typedef logic [OSF_STRB_W-1:0] osf_strb_t;  // byte enables.
  typedef logic [OSF_USER_W-1:0] osf_user_t;

  // forward half of a stream, 76 bits.
  // tvalid sits at the msb.
  typedef struct packed {
    logic      tvalid;
    logic      tlast;
    osf_user_t tuser;
    osf_strb_t tstrb;
    osf_data_t tdata;
  } axis_bus_t;

endpackage
